// ==== bench/uart_fifo_pack_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

module uart_fifo_pack_tb import uart_pkg::*; ();

    localparam int CLK_PERIOD   = 10;    // ns
    localparam int READY_LIMIT  = 1000;  // Covers a stall of one full frame
    localparam int FILTER_LIMIT = 20;    // Window for accesses that must stay unanswered
    // Frames: baud 1, transmit 2 + 10, receive 3, overrun 9
    localparam int TOTAL_FRAMES    = 25;
    localparam int WATCHDOG_CYCLES = TOTAL_FRAMES * 10 * 16 + 3000;

    logic                 clk;
    logic                 rst;
    logic                 rxd;
    logic                 txd;
    logic                 irq_rx_valid;
    prescale_t            prescale_out;
    logic [FWD_WIDTH-1:0] mem_packed_fwd;
    logic [RET_WIDTH-1:0] mem_packed_ret;

    int          errors = 0;
    int          checks = 0;
    int          bit_cycles = 16;             // Serial bit time as programmed
    logic [31:0] lcg_state = 32'h22622773;
    byte_t       tx_expect[$];                // Bytes queued for the TX path

    uart_fifo_pack uart_fifo_pack_inst (
        .clk           (clk),
        .rst           (rst),
        .rxd           (rxd),
        .txd           (txd),
        .irq_rx_valid  (irq_rx_valid),
        .prescale_out  (prescale_out),
        .mem_packed_fwd(mem_packed_fwd),
        .mem_packed_ret(mem_packed_ret)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Compare tasks ----------------
    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_status(input string name, input status_t got, input status_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_prescale(input string name, input prescale_t got, input prescale_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    // Single-cycle response rule for unstalled accesses
    task automatic check_latency(input string name, input int lat);
        checks++;
        if (lat != 1) begin
            errors++;
            $display("Mismatch %s ready latency: got %0h expected %0h", name, lat, 1);
        end
    endtask

    // Helpers ----------------------
    function automatic byte_t rand_byte();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[23:16];  // Upper bits are the better ones
    endfunction

    function automatic word_t reg_addr(input logic [7:0] base, input logic [3:0] offset);
        return {base, 20'h0, offset};
    endfunction

    // Every stimulus step ends 1 ns after a rising edge
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // Bus driver -------------------
    // lat counts edges until ready shows on the return vector, 0 if it never came
    task automatic bus_access(input word_t addr, input word_t wdata, input strb_t wstrb,
                              input int limit, output word_t rdata, output int lat);
        lat   = 0;
        rdata = '0;
        mem_packed_fwd = {1'b1, addr, wdata, wstrb};
        for (int i = 1; i <= limit && lat == 0; i++) begin
            wait_cycles(1);
            if (mem_packed_ret[RET_WIDTH-1]) begin
                lat   = i;
                rdata = mem_packed_ret[31:0];
            end
        end
        mem_packed_fwd = '0;   // Drop valid
        wait_cycles(1);        // At least one idle cycle between accesses
    endtask

    task automatic reg_write(input logic [3:0] offset, input word_t wdata, input strb_t wstrb,
                             output int lat);
        word_t unused;
        bus_access(reg_addr(UART_BASE, offset), wdata, wstrb, READY_LIMIT, unused, lat);
        if (lat == 0) begin
            errors++;
            $display("Error: write to offset %h never got ready", offset);
        end
    endtask

    task automatic reg_read(input logic [3:0] offset, output word_t rdata, output int lat);
        bus_access(reg_addr(UART_BASE, offset), 32'h0, 4'b0000, READY_LIMIT, rdata, lat);
        if (lat == 0) begin
            errors++;
            $display("Error: read of offset %h never got ready", offset);
        end
    endtask

    // Serial model -----------------
    task automatic monitor_frame(output byte_t data);
        int waited;
        waited = 0;
        data   = '0;
        while (txd !== 1'b0 && waited < 40 * bit_cycles) begin
            wait_cycles(1);
            waited++;
        end
        if (txd !== 1'b0) begin
            errors++;
            $display("Error: no start bit appeared on txd");
        end else begin
            wait_cycles(bit_cycles / 2);  // Middle of start bit
            check_bit("txd start bit", txd, 1'b0);
            for (int k = 0; k < 8; k++) begin
                wait_cycles(bit_cycles);
                data[k] = txd;            // LSB first
            end
            wait_cycles(bit_cycles);
            check_bit("txd stop bit", txd, 1'b1);
        end
    endtask

    task automatic send_frame(input byte_t data);
        rxd = 1'b0;
        wait_cycles(bit_cycles);
        for (int k = 0; k < 8; k++) begin
            rxd = data[k];
            wait_cycles(bit_cycles);
        end
        rxd = 1'b1;   // Stop bit, line stays idle after
        wait_cycles(bit_cycles);
    endtask

    // Writes tx_expect while the monitor collects the frames
    task automatic transmit_queue(output int max_lat);
        int    w_lat;
        int    w_max;
        int    n;
        word_t rd;
        byte_t got;
        n     = tx_expect.size();
        w_max = 0;
        fork
            begin
                for (int i = 0; i < n; i++) begin
                    reg_write(UART_TX_REG, {24'h0, tx_expect[i]}, 4'b0001, w_lat);
                    if (w_lat > w_max) w_max = w_lat;
                end
                reg_read(UART_STATUS, rd, w_lat);   // Frames still pending here
                check_status("status tx_busy", status_t'(rd[3:0]) & 4'b0100, 4'b0100);
            end
            begin
                for (int i = 0; i < n; i++) begin
                    monitor_frame(got);
                    check_byte("txd data", got, tx_expect[i]);
                end
            end
        join
        max_lat = w_max;
        tx_expect.delete();
    endtask

    // Fails on any low level of txd during the window
    task automatic watch_txd_idle(input int n);
        for (int i = 0; i < n; i++) begin
            wait_cycles(1);
            check_bit("txd idle", txd, 1'b1);
        end
    endtask

    // Tests ------------------------
    task automatic test_reset();
        word_t rd;
        int    lat;
        check_bit("txd", txd, 1'b1);
        check_bit("irq_rx_valid", irq_rx_valid, 1'b0);
        check_prescale("prescale_out", prescale_out, 16'd16);
        reg_read(UART_STATUS, rd, lat);
        check_word("status", rd, 32'h0);
        check_latency("status read", lat);
    endtask

    task automatic test_baud();
        int lat;
        reg_write(UART_BAUDRATE, 32'hFFFF_FF0C, 4'b0001, lat);  // Low lane only
        check_latency("baud write", lat);
        check_prescale("prescale_out", prescale_out, 16'h000C);
        reg_write(UART_BAUDRATE, 32'h0000_0008, 4'b1111, lat);
        check_latency("baud write", lat);
        check_prescale("prescale_out", prescale_out, 16'h0008);
        bit_cycles = 8;
        tx_expect.push_back(8'h96);   // Frame at the new bit time
        transmit_queue(lat);
        check_latency("tx write", lat);
    endtask

    task automatic test_transmit();
        int max_lat;
        tx_expect.push_back(8'hA5);
        tx_expect.push_back(8'h3C);
        transmit_queue(max_lat);
        check_latency("tx write", max_lat);
        // Overfill the FIFO so one write has to wait for a free slot
        for (int i = 0; i < FIFO_DEPTH + 2; i++) tx_expect.push_back(rand_byte());
        transmit_queue(max_lat);
        if (max_lat <= 1) begin
            errors++;
            $display("Error: no tx write was held back by a full FIFO");
        end
    endtask

    task automatic test_receive();
        byte_t sent[3];
        word_t rd;
        int    lat;
        foreach (sent[i]) begin
            sent[i] = rand_byte();
            send_frame(sent[i]);
        end
        wait_cycles(2 * bit_cycles);   // Last done strobe lands after mid stop bit
        check_bit("irq_rx_valid", irq_rx_valid, 1'b1);
        foreach (sent[i]) begin
            reg_read(UART_RX_REG, rd, lat);
            check_word("rx data", rd, {24'h0, sent[i]});
            check_latency("rx read", lat);
        end
        reg_read(UART_RX_REG, rd, lat);
        check_word("rx data on empty", rd, 32'hFFFF_FF00);
        check_bit("irq_rx_valid", irq_rx_valid, 1'b0);
    endtask

    task automatic test_overrun();
        byte_t sent[FIFO_DEPTH + 1];
        word_t rd;
        int    lat;
        foreach (sent[i]) begin
            sent[i] = rand_byte();
            send_frame(sent[i]);
        end
        wait_cycles(2 * bit_cycles);
        reg_read(UART_STATUS, rd, lat);
        check_status("status", status_t'(rd[3:0]), 4'b1001);  // Overrun plus data waiting
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            reg_read(UART_RX_REG, rd, lat);
            check_word("rx data", rd, {24'h0, sent[i]});
        end
        reg_read(UART_STATUS, rd, lat);   // Overrun cleared by the first read
        check_status("status", status_t'(rd[3:0]), 4'b0000);
    endtask

    task automatic filter_one(input string name, input word_t addr, input word_t wdata);
        word_t rd;
        int    lat;
        fork
            bus_access(addr, wdata, 4'b1111, FILTER_LIMIT, rd, lat);
            watch_txd_idle(FILTER_LIMIT + 10);
        join
        if (lat != 0) begin
            errors++;
            $display("Error: %s got ready although it should be ignored", name);
        end
    endtask

    task automatic test_filter();
        word_t rd;
        int    lat;
        filter_one("baud write to another base", reg_addr(8'h01, UART_BAUDRATE), 32'h0000_0033);
        filter_one("tx write to another base", reg_addr(8'h80, UART_TX_REG), 32'h0000_0055);
        filter_one("write to unmapped offset", reg_addr(UART_BASE, 4'h6), 32'h0000_0044);
        check_prescale("prescale_out", prescale_out, 16'h0008);
        reg_read(UART_STATUS, rd, lat);   // Nothing may have been queued for TX
        check_status("status", status_t'(rd[3:0]), 4'b0000);
    endtask

    // Main sequence ----------------
    initial begin
        rst            = 1'b1;
        rxd            = 1'b1;
        mem_packed_fwd = '0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        wait_cycles(2);

        test_reset();
        test_baud();
        test_transmit();
        test_receive();
        test_overrun();
        test_filter();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // Watchdog, sized for all frames at the slowest bit time
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Checks: %0d, errors: %0d", checks, errors + 1);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build the UART testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f uart_fifo_pack.f \
    --top-module uart_fifo_pack_tb -o uart_fifo_pack_sim

./obj_dir/uart_fifo_pack_sim | tee sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
    echo "Simulation result: pass"
else
    echo "Simulation result: fail"
    exit 1
fi

// ==== uart_fifo_pack.f ====
verilog/uart_pkg.sv
verilog/mem_bus_if.sv
verilog/uart_fifo_if.sv
verilog/munpack.sv
verilog/byte_fifo.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_stream.sv
verilog/uart_regs.sv
verilog/uart_fifo_pack.sv
bench/uart_fifo_pack_tb.sv

// ==== verilog/byte_fifo.sv ====
`default_nettype none
`timescale 1ns/1ps

module byte_fifo import uart_pkg::*; #(
    parameter int DEPTH = FIFO_DEPTH
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  push,
    input  byte_t din,
    input  logic  pop,
    output byte_t dout,   // Head word, no read latency
    output logic  empty,
    output logic  full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    byte_t             mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              do_push;
    logic              do_pop;

    assign do_push = push && !full;   // Guarded, caller must not overfill
    assign do_pop  = pop && !empty;
    assign empty   = (count == '0);
    assign full    = (count == CNT_W'(DEPTH));
    assign dout    = mem[rd_ptr];

    // Storage, no reset
    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= din;
    end

    // Pointers and occupancy ---------
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;  // Wrap
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;  // Both or neither
            endcase
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (rst) push |-> !full)
        else $error("push into full FIFO");
    a_no_underflow: assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
        else $error("pop from empty FIFO");

endmodule

`default_nettype wire

// ==== verilog/mem_bus_if.sv ====
`default_nettype none
`timescale 1ns/1ps

// Native memory bus after unpacking
interface mem_bus_if import uart_pkg::*; ();

    logic  valid;  // Held by the core until ready
    word_t addr;
    word_t wdata;
    strb_t wstrb;  // All zero means read
    logic  ready;  // One-cycle response
    word_t rdata;

    // Unpacker side, faces the core
    modport host (
        output valid, addr, wdata, wstrb,
        input  ready, rdata
    );

    // Register block side
    modport device (
        input  valid, addr, wdata, wstrb,
        output ready, rdata
    );

endinterface

`default_nettype wire

// ==== verilog/munpack.sv ====
`default_nettype none
`timescale 1ns/1ps

module munpack import uart_pkg::*; (
    input  logic                 clk,
    input  logic [FWD_WIDTH-1:0] mem_packed_fwd,
    output logic [RET_WIDTH-1:0] mem_packed_ret,
    mem_bus_if.host              bus
);

    // Forward path -------------------
    // Layout from MSB: valid, addr, wdata, wstrb
    assign bus.valid = mem_packed_fwd[68];
    assign bus.addr  = mem_packed_fwd[67:36];
    assign bus.wdata = mem_packed_fwd[35:4];
    assign bus.wstrb = mem_packed_fwd[3:0];

    // Return path --------------------
    // Device computes its response in the accept cycle, the flop
    // here makes it visible on the next cycle without glitches
    always_ff @(posedge clk) begin
        mem_packed_ret <= {bus.ready, bus.rdata};  // ready on top
    end

endmodule

`default_nettype wire

// ==== verilog/uart_fifo_if.sv ====
`default_nettype none
`timescale 1ns/1ps

// Register block <-> FIFO/serial datapath
interface uart_fifo_if import uart_pkg::*; ();

    byte_t     tx_data;
    logic      tx_push;    // Single-cycle strobe
    logic      tx_full;
    byte_t     rx_data;    // Head of RX FIFO, valid with rx_valid
    logic      rx_valid;
    logic      rx_pop;     // Single-cycle strobe
    status_t   status;
    logic      ovr_clear;  // Clears sticky overrun
    prescale_t prescale;

    modport regs (
        output tx_data, tx_push, rx_pop, ovr_clear, prescale,
        input  tx_full, rx_data, rx_valid, status
    );

    modport stream (
        input  tx_data, tx_push, rx_pop, ovr_clear, prescale,
        output tx_full, rx_data, rx_valid, status
    );

endinterface

`default_nettype wire

// ==== verilog/uart_fifo_pack.sv ====
`default_nettype none
`timescale 1ns/1ps

module uart_fifo_pack import uart_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rxd,
    output logic                 txd,
    output logic                 irq_rx_valid,    // RX data waiting
    output prescale_t            prescale_out,
    input  logic [FWD_WIDTH-1:0] mem_packed_fwd,  // Core -> UART
    output logic [RET_WIDTH-1:0] mem_packed_ret   // UART -> core
);

    mem_bus_if   bus_if ();
    uart_fifo_if fifo_if ();

    munpack munpack_inst (
        .clk           (clk),
        .mem_packed_fwd(mem_packed_fwd),
        .mem_packed_ret(mem_packed_ret),
        .bus           (bus_if)
    );

    uart_regs uart_regs_inst (
        .clk (clk),
        .rst (rst),
        .bus (bus_if),
        .fifo(fifo_if)
    );

    uart_stream uart_stream_inst (
        .clk (clk),
        .rst (rst),
        .fifo(fifo_if),
        .rxd (rxd),
        .txd (txd)
    );

    assign irq_rx_valid = fifo_if.status[0];
    assign prescale_out = fifo_if.prescale;

endmodule

`default_nettype wire

// ==== verilog/uart_pkg.sv ====
`default_nettype none

package uart_pkg;

    // Widths ----------------------
    localparam int BYTE_W    = 8;   // UART character width
    localparam int FWD_WIDTH = 69;  // valid + addr + wdata + wstrb
    localparam int RET_WIDTH = 33;  // ready + rdata

    typedef logic [31:0]       word_t;      // Bus address and data
    typedef logic [3:0]        strb_t;      // Byte lane strobes
    typedef logic [BYTE_W-1:0] byte_t;      // One serial character
    typedef logic [15:0]       prescale_t;  // Clocks per bit
    typedef logic [3:0]        status_t;    // {ovr, tx_busy, tx_full, rx_valid}

    // Register map ----------------
    localparam logic [7:0] UART_BASE     = 8'h00;  // addr[31:24]
    localparam logic [3:0] UART_TX_REG   = 4'h0;
    localparam logic [3:0] UART_STATUS   = 4'h4;
    localparam logic [3:0] UART_RX_REG   = 4'h8;
    localparam logic [3:0] UART_BAUDRATE = 4'hC;

    localparam int        FIFO_DEPTH     = 8;
    localparam prescale_t PRESCALE_RESET = 16'd16;
    localparam word_t     RX_EMPTY_FLAG  = 32'hFFFF_FF00;  // Read of an empty RX FIFO

    // Serial FSM states
    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;
    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

endpackage

`default_nettype wire

// ==== verilog/uart_regs.sv ====
`default_nettype none
`timescale 1ns/1ps

module uart_regs import uart_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    mem_bus_if.device bus,
    uart_fifo_if.regs fifo
);

    logic [3:0] offset;      // Register offset inside the window
    logic       is_write;
    logic       hit;         // Pending access for this peripheral
    logic       served;      // Set once ready went out for this access
    logic       baud_wr;
    prescale_t  prescale_q;

    assign offset   = bus.addr[3:0];
    assign is_write = |bus.wstrb;
    assign hit      = bus.valid && (bus.addr[31:24] == UART_BASE) && !served;

    assign fifo.tx_data  = bus.wdata[BYTE_W-1:0];  // Low lane only
    assign fifo.prescale = prescale_q;

    // Access decode ------------------
    always_comb begin
        bus.ready      = 1'b0;
        bus.rdata      = '0;
        fifo.tx_push   = 1'b0;
        fifo.rx_pop    = 1'b0;
        fifo.ovr_clear = 1'b0;
        baud_wr        = 1'b0;
        if (hit) begin
            case (offset)
                UART_TX_REG: begin
                    // Full FIFO stalls the core, access stays pending
                    if (is_write && !fifo.tx_full) begin
                        bus.ready    = 1'b1;
                        fifo.tx_push = bus.wstrb[0];  // No lane 0, nothing queued
                    end
                end
                UART_STATUS: begin
                    if (!is_write) begin
                        bus.ready      = 1'b1;
                        bus.rdata      = word_t'(fifo.status);
                        fifo.ovr_clear = 1'b1;  // Read clears overrun
                    end
                end
                UART_RX_REG: begin
                    if (!is_write) begin
                        bus.ready   = 1'b1;
                        fifo.rx_pop = fifo.rx_valid;
                        bus.rdata   = fifo.rx_valid ? word_t'(fifo.rx_data) : RX_EMPTY_FLAG;
                    end
                end
                UART_BAUDRATE: begin
                    if (is_write) begin
                        bus.ready = 1'b1;
                        baud_wr   = 1'b1;
                    end
                end
                default: ;  // Unmapped, never answered
            endcase
        end
    end

    // Served flag and prescale -------
    always_ff @(posedge clk) begin
        if (rst) begin
            served     <= 1'b0;
            prescale_q <= PRESCALE_RESET;
        end else begin
            if (!bus.valid) begin
                served <= 1'b0;        // Core ended the access
            end else if (bus.ready) begin
                served <= 1'b1;
            end
            if (baud_wr) begin
                if (bus.wstrb[0]) prescale_q[7:0]  <= bus.wdata[7:0];
                if (bus.wstrb[1]) prescale_q[15:8] <= bus.wdata[15:8];
            end
        end
    end

    // Stalled TX write stays on the bus until it is served
    a_stall_held: assert property (
        @(posedge clk) disable iff (rst)
        hit && offset == UART_TX_REG && is_write && !bus.ready |=> bus.valid
    ) else $error("pending TX write dropped before ready");

endmodule

`default_nettype wire

// ==== verilog/uart_rx.sv ====
`default_nettype none
`timescale 1ns/1ps

module uart_rx import uart_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      rxd,
    input  prescale_t prescale,
    output logic      done,      // One cycle, data valid
    output byte_t     data
);

    logic        rxd_s1;
    logic        rxd_s2;        // Synchronized line
    rx_state_t   state;
    prescale_t   cnt;
    logic [16:0] cnt_next;
    logic        half_end;      // Middle of start bit
    logic        bit_end;       // One full bit later
    logic [2:0]  bit_idx;

    assign cnt_next = {1'b0, cnt} + 17'd1;
    assign half_end = (cnt_next >= {2'b00, prescale[15:1]});
    assign bit_end  = (cnt_next >= {1'b0, prescale});

    // Input synchronizer -------------
    always_ff @(posedge clk) begin
        if (rst) begin
            rxd_s1 <= 1'b1;
            rxd_s2 <= 1'b1;
        end else begin
            rxd_s1 <= rxd;
            rxd_s2 <= rxd_s1;
        end
    end

    // Frame FSM ----------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= RX_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            cnt  <= cnt_next[15:0];
            case (state)
                RX_IDLE: begin
                    cnt <= '0;
                    if (!rxd_s2) state <= RX_START;   // Falling edge
                end
                RX_START: begin
                    if (half_end) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rxd_s2 ? RX_IDLE : RX_DATA;   // Glitch rejected
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= RX_STOP;
                    end
                end
                RX_STOP: begin
                    if (bit_end) begin
                        state <= RX_IDLE;
                        done  <= rxd_s2;   // Framing error drops the byte
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // Shift in LSB first at mid-bit
    always_ff @(posedge clk) begin
        if (state == RX_DATA && bit_end) data <= {rxd_s2, data[BYTE_W-1:1]};
    end

endmodule

`default_nettype wire

// ==== verilog/uart_stream.sv ====
`default_nettype none
`timescale 1ns/1ps

module uart_stream import uart_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    uart_fifo_if.stream fifo,
    input  logic        rxd,
    output logic        txd
);

    byte_t tx_head;    // Next byte to send
    logic  tx_empty;
    logic  tx_start;
    logic  tx_busy;    // Frame in flight
    byte_t rx_byte;
    logic  rx_done;
    logic  rx_empty;
    logic  rx_full;
    logic  rx_push;
    logic  ovr;        // Sticky overrun

    // Transmit side ------------------
    byte_fifo tx_fifo_inst (
        .clk  (clk),
        .rst  (rst),
        .push (fifo.tx_push),
        .din  (fifo.tx_data),
        .pop  (tx_start),
        .dout (tx_head),
        .empty(tx_empty),
        .full (fifo.tx_full)
    );

    assign tx_start = !tx_empty && !tx_busy;  // Feed idle serializer

    uart_tx uart_tx_inst (
        .clk     (clk),
        .rst     (rst),
        .start   (tx_start),
        .data    (tx_head),
        .prescale(fifo.prescale),
        .busy    (tx_busy),
        .txd     (txd)
    );

    // Receive side -------------------
    uart_rx uart_rx_inst (
        .clk     (clk),
        .rst     (rst),
        .rxd     (rxd),
        .prescale(fifo.prescale),
        .done    (rx_done),
        .data    (rx_byte)
    );

    assign rx_push = rx_done && !rx_full;  // Byte lost when full

    byte_fifo rx_fifo_inst (
        .clk  (clk),
        .rst  (rst),
        .push (rx_push),
        .din  (rx_byte),
        .pop  (fifo.rx_pop),
        .dout (fifo.rx_data),
        .empty(rx_empty),
        .full (rx_full)
    );

    assign fifo.rx_valid = !rx_empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            ovr <= 1'b0;
        end else if (rx_done && rx_full) begin
            ovr <= 1'b1;  // New loss wins over a clear
        end else if (fifo.ovr_clear) begin
            ovr <= 1'b0;
        end
    end

    assign fifo.status = {ovr, !tx_empty || tx_busy, fifo.tx_full, !rx_empty};

endmodule

`default_nettype wire

// ==== verilog/uart_tx.sv ====
`default_nettype none
`timescale 1ns/1ps

module uart_tx import uart_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      start,     // Load data, idle only
    input  byte_t     data,
    input  prescale_t prescale,
    output logic      busy,
    output logic      txd
);

    tx_state_t   state;
    prescale_t   cnt;        // Cycles into current bit
    logic [16:0] cnt_next;
    logic        bit_end;
    logic [2:0]  bit_idx;
    byte_t       shreg;      // Remaining data bits, LSB out first

    assign cnt_next = {1'b0, cnt} + 17'd1;
    assign bit_end  = (cnt_next >= {1'b0, prescale});
    assign busy     = (state != TX_IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= TX_IDLE;
            txd     <= 1'b1;   // Line idles high
            cnt     <= '0;
            bit_idx <= '0;
        end else begin
            cnt <= bit_end ? '0 : cnt_next[15:0];
            case (state)
                TX_IDLE: begin
                    cnt <= '0;
                    if (start) begin
                        state <= TX_START;
                        txd   <= 1'b0;   // Start bit
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        state   <= TX_DATA;
                        txd     <= shreg[0];
                        bit_idx <= '0;
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        if (bit_idx == 3'd7) begin
                            state <= TX_STOP;
                            txd   <= 1'b1;   // Stop bit
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            txd     <= shreg[bit_idx + 1'b1];
                        end
                    end
                end
                TX_STOP: begin
                    if (bit_end) state <= TX_IDLE;
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Payload register
    always_ff @(posedge clk) begin
        if (state == TX_IDLE && start) shreg <= data;
    end

    a_idle_high: assert property (@(posedge clk) disable iff (rst) (state == TX_IDLE) |-> txd)
        else $error("txd low while transmitter idle");

endmodule

`default_nettype wire
